// ==== Bender.yml ====
package:
  name: ncpu_msr

sources:
  # Package first, then the blocks, then the top level
  - files:
      - verilog/ncpu_msr_pkg.sv
      - verilog/ncpu_msr_cmd_decode.sv
      - verilog/ncpu_msr_file.sv
      - verilog/ncpu_msr_read.sv
      - verilog/ncpu_msr_top.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_ncpu_msr.sv

// ==== ncpu_msr.f ====
+incdir+verification
verilog/ncpu_msr_pkg.sv
verilog/ncpu_msr_cmd_decode.sv
verilog/ncpu_msr_file.sv
verilog/ncpu_msr_read.sv
verilog/ncpu_msr_top.sv
verification/tb_ncpu_msr.sv

// ==== verification/tb_ncpu_msr_table.svh ====
// Directed stimulus table for the MSR testbench, one entry per clock cycle
`ifndef TB_NCPU_MSR_TABLE_SVH
`define TB_NCPU_MSR_TABLE_SVH

// Columns: name, we, waddr, wdat, exp_ent, exp_pc, exp_lsa, eret, raddr, rnd
// rnd set means wdat, exp_pc and exp_lsa are replaced by random words
task automatic fill_table();
   // Reset values
   add_step("reset_psr",      0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    0);
   add_step("reset_cpuid",    0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_CPUID,  0);
   add_step("reset_epsr",     0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPSR,   0);
   add_step("reset_epc",      0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPC,    0);
   add_step("reset_elsa",     0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_ELSA,   0);
   add_step("reset_coreid",   0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_COREID, 0);
   add_step("reset_unmapped", 0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, addr_6,     0);

   // Software writes, bypass in the same cycle and hold after the edge
   add_step("wr_psr_all",     1, MSR_PSR,    32'hffff_ffff, 0, 32'h0, 32'h0, 0, MSR_PSR, 0);
   add_step("hold_psr_all",   0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    0);
   add_step("wr_psr_rand",    1, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    1);
   add_step("wr_epsr_rand",   1, MSR_EPSR,   32'h0, 0, 32'h0, 32'h0, 0, MSR_EPSR,   1);
   add_step("hold_epsr",      0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPSR,   0);
   add_step("wr_epc_rand",    1, MSR_EPC,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPC,    1);
   add_step("hold_epc",       0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPC,    0);
   add_step("wr_elsa_rand",   1, MSR_ELSA,   32'h0, 0, 32'h0, 32'h0, 0, MSR_ELSA,   1);
   add_step("hold_elsa",      0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_ELSA,   0);

   // Read-only and unmapped targets ignore writes
   add_step("wr_cpuid_ign",   1, MSR_CPUID,  32'h0, 0, 32'h0, 32'h0, 0, MSR_EPSR,   1);
   add_step("wr_coreid_ign",  1, MSR_COREID, 32'h0, 0, 32'h0, 32'h0, 0, MSR_ELSA,   1);
   add_step("wr_addr6_ign",   1, addr_6,     32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    1);
   add_step("wr_addr7_ign",   1, addr_7,     32'h0, 0, 32'h0, 32'h0, 0, MSR_EPC,    1);
   add_step("rd_addr7",       0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, addr_7,     0);

   // Exception entry
   add_step("prep_psr_all",   1, MSR_PSR,    32'h0000_00f1, 0, 32'h0, 32'h0, 0, MSR_PSR, 0);
   add_step("exc_entry",      0, MSR_PSR,    32'h0, 1, 32'h0, 32'h0, 0, MSR_PSR,    1);
   add_step("exc_saved_epsr", 0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPSR,   0);
   add_step("exc_saved_epc",  0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPC,    0);
   add_step("exc_saved_elsa", 0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_ELSA,   0);
   add_step("exc_ovr_epc",    1, MSR_EPC,    32'h0, 1, 32'h0, 32'h0, 0, MSR_EPC,    1);
   add_step("exc_ovr_epsr",   1, MSR_EPSR,   32'h0000_00e0, 1, 32'h5000, 32'h6000, 0, MSR_EPSR, 0);
   add_step("exc_ovr_elsa",   1, MSR_ELSA,   32'h0, 1, 32'h0, 32'h0, 0, MSR_ELSA,   1);

   // Exception return restores the saved status word
   add_step("prep_psr_e1",    1, MSR_PSR,    32'h0000_00e1, 0, 32'h0, 32'h0, 0, MSR_PSR, 0);
   add_step("exc_save_e1",    0, MSR_PSR,    32'h0, 1, 32'h0, 32'h0, 0, MSR_EPSR,   1);
   add_step("clr_psr",        1, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    0);
   add_step("eret_restore",   0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 1, MSR_PSR,    0);
   add_step("hold_eret",      0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    0);

   // PSR write in the cycle of exception entry
   add_step("wr_ent_cc1",     1, MSR_PSR,    32'h0000_00e1, 1, 32'h1000, 32'h2000, 0, MSR_PSR, 0);
   add_step("wr_ent_cc0",     1, MSR_PSR,    32'h0000_00e0, 1, 32'h3000, 32'h4000, 0, MSR_PSR, 0);
   add_step("after_ent_cc0",  0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_EPSR,   0);
   add_step("after_ent_psr",  0, MSR_PSR,    32'h0, 0, 32'h0, 32'h0, 0, MSR_PSR,    0);
endtask

`endif

// ==== verification/tb_ncpu_msr.sv ====
// Testbench for the MSR block: clock, reset, table loop, reference model, checks, timeout
`timescale 1ns/10ps
`default_nettype none

module tb_ncpu_msr;
   import ncpu_msr_pkg::*;

   localparam int          RESET_CYCLES = 8;
   localparam int unsigned RAND_SEED    = 32'h581217c6;
   // Version 1, features IMM, DMM, IRQC and TSC
   localparam word_t       EXP_CPUID    = 32'h030c_0001;
   localparam msr_addr_t   addr_6       = msr_addr_t'(3'd6);
   localparam msr_addr_t   addr_7       = msr_addr_t'(3'd7);

   typedef struct {
      string     name;
      logic      we;
      msr_addr_t waddr;
      word_t     wdat;
      logic      ent;
      word_t     pc;
      word_t     lsa;
      logic      ret;
      msr_addr_t raddr;
      logic      rnd;
   } entry_t;

   logic       clk;
   logic       arst_n;
   logic       msr_we;
   msr_addr_t  msr_waddr;
   word_t      msr_wdat;
   logic       exp_ent;
   word_t      exp_pc;
   word_t      exp_lsa;
   logic       eret;
   msr_addr_t  msr_raddr;
   wire word_t msr_rdat;
   wire psr_t  psr;
   wire psr_t  psr_nold;

   entry_t      tbl[$];
   entry_t      cur;
   int          cycles;
   int          cycle_limit;

   // Reference model registers and views
   psr_t  m_psr;
   psr_t  m_epsr;
   word_t m_epc;
   word_t m_elsa;
   psr_t  v_psr;
   psr_t  v_nold;
   psr_t  v_epsr;
   word_t v_epc;
   word_t v_elsa;
   word_t v_rdat;

   ncpu_msr_top dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .msr_we    (msr_we),
      .msr_waddr (msr_waddr),
      .msr_wdat  (msr_wdat),
      .exp_ent   (exp_ent),
      .exp_pc    (exp_pc),
      .exp_lsa   (exp_lsa),
      .eret      (eret),
      .msr_raddr (msr_raddr),
      .msr_rdat  (msr_rdat),
      .psr       (psr),
      .psr_nold  (psr_nold)
   );

   function automatic void add_step(input string name, input logic we, input msr_addr_t waddr,
                                    input word_t wdat, input logic ent, input word_t pc,
                                    input word_t lsa, input logic ret, input msr_addr_t raddr,
                                    input logic rnd);
      entry_t e;
      e = '{name, we, waddr, wdat, ent, pc, lsa, ret, raddr, rnd};
      tbl.push_back(e);
   endfunction

   `include "tb_ncpu_msr_table.svh"

   // Keep only the five implemented status bits
   function automatic psr_t status_bits(input word_t w);
      psr_t p;
      p           = '0;
      p[PSR_CC]   = w[PSR_CC];
      p[PSR_RM]   = w[PSR_RM];
      p[PSR_IRE]  = w[PSR_IRE];
      p[PSR_IMME] = w[PSR_IMME];
      p[PSR_DMME] = w[PSR_DMME];
      return p;
   endfunction

   task automatic check_value(input string name, input string what, input word_t exp_v,
                              input word_t act_v);
      if (exp_v !== act_v) begin
         $display("ERROR: test %s, %s expected %h actual %h", name, what, exp_v, act_v);
         $display("test failed");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   task automatic model_views(input entry_t e);
      v_nold = m_psr;
      if (e.ret) begin
         v_nold = status_bits({22'b0, m_epsr});
      end else if (e.we && e.waddr == MSR_PSR) begin
         v_nold = status_bits(e.wdat);
      end
      // Entry forces root mode and masks interrupts and MMUs, cc stays
      v_psr = v_nold;
      if (e.ent) begin
         v_psr[PSR_RM]   = 1'b1;
         v_psr[PSR_IRE]  = 1'b0;
         v_psr[PSR_IMME] = 1'b0;
         v_psr[PSR_DMME] = 1'b0;
      end
      v_epsr = m_epsr;
      v_epc  = m_epc;
      v_elsa = m_elsa;
      if (e.ent) begin
         v_epsr = m_psr;
         v_epc  = e.pc;
         v_elsa = e.lsa;
      end else if (e.we) begin
         if (e.waddr == MSR_EPSR) v_epsr = status_bits(e.wdat);
         if (e.waddr == MSR_EPC) v_epc = e.wdat;
         if (e.waddr == MSR_ELSA) v_elsa = e.wdat;
      end
      case (e.raddr)
         MSR_PSR:    v_rdat = {22'b0, v_psr};
         MSR_CPUID:  v_rdat = EXP_CPUID;
         MSR_EPSR:   v_rdat = {22'b0, v_epsr};
         MSR_EPC:    v_rdat = v_epc;
         MSR_ELSA:   v_rdat = v_elsa;
         default:    v_rdat = '0;
      endcase
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Run limit in clock cycles
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: the run went past %0d clock cycles", cycle_limit);
         $display("test failed");
         $fatal(1, "run limit reached");
      end
   end

   initial begin
      cycles      = 0;
      cycle_limit = 0;
      arst_n      = 1'b0;
      msr_we      = 1'b0;
      msr_waddr   = MSR_PSR;
      msr_wdat    = '0;
      exp_ent     = 1'b0;
      exp_pc      = '0;
      exp_lsa     = '0;
      eret        = 1'b0;
      msr_raddr   = MSR_PSR;
      void'($urandom(RAND_SEED));
      fill_table();
      cycle_limit = tbl.size() + RESET_CYCLES + 20;
      m_psr  = 10'h010;
      m_epsr = '0;
      m_epc  = '0;
      m_elsa = '0;

      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;

      foreach (tbl[i]) begin
         cur = tbl[i];
         if (cur.rnd) begin
            cur.wdat = $urandom;
            cur.pc   = $urandom;
            cur.lsa  = $urandom;
         end
         @(posedge clk);
         #1;
         msr_we    = cur.we;
         msr_waddr = cur.waddr;
         msr_wdat  = cur.wdat;
         exp_ent   = cur.ent;
         exp_pc    = cur.pc;
         exp_lsa   = cur.lsa;
         eret      = cur.ret;
         msr_raddr = cur.raddr;
         @(negedge clk);
         model_views(cur);
         check_value(cur.name, "msr_rdat", v_rdat, msr_rdat);
         check_value(cur.name, "psr", {22'b0, v_psr}, {22'b0, psr});
         check_value(cur.name, "psr_nold", {22'b0, v_nold}, {22'b0, psr_nold});
         // Views become the register contents at the next edge
         m_psr  = v_psr;
         m_epsr = v_epsr;
         m_epc  = v_epc;
         m_elsa = v_elsa;
      end

      @(posedge clk);
      #1;
      msr_we  = 1'b0;
      exp_ent = 1'b0;
      eret    = 1'b0;
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/ncpu_msr_cmd_decode.sv ====
// MSR command decoder: software writes, exception entry and return to write strobes
`timescale 1ns/10ps
`default_nettype none

module ncpu_msr_cmd_decode (
   input  wire                            clk,
   input  wire                            arst_n,
   // Software write port
   input  wire                            msr_we,
   input  wire ncpu_msr_pkg::msr_addr_t   msr_waddr,
   input  wire ncpu_msr_pkg::word_t       msr_wdat,
   // Exception control
   input  wire                            exp_ent,
   input  wire ncpu_msr_pkg::word_t       exp_pc,
   input  wire ncpu_msr_pkg::word_t       exp_lsa,
   input  wire                            eret,
   // Registered state from the file
   input  wire ncpu_msr_pkg::msr_state_t  state,
   output ncpu_msr_pkg::msr_wcmd_t        wcmd
);
   import ncpu_msr_pkg::*;

   logic psr_sel;
   logic epsr_sel;
   logic epc_sel;
   logic elsa_sel;
   logic psr_upd;
   psr_t psr_src;

   // Address decode, CPUID, COREID and unmapped codes select nothing
   assign psr_sel  = msr_we && (msr_waddr == MSR_PSR);
   assign epsr_sel = msr_we && (msr_waddr == MSR_EPSR);
   assign epc_sel  = msr_we && (msr_waddr == MSR_EPC);
   assign elsa_sel = msr_we && (msr_waddr == MSR_ELSA);

   // Return from exception wins over a software PSR write
   assign psr_upd = psr_sel | eret;
   assign psr_src = eret ? state.epsr_q : msr_wdat[PSR_W-1:0];

   always_comb begin
      wcmd = '0;

      // All PSR fields move together
      wcmd.cc_we    = psr_upd;
      wcmd.cc_nxt   = psr_src[PSR_CC];
      wcmd.rm_we    = psr_upd;
      wcmd.rm_nxt   = psr_src[PSR_RM];
      wcmd.ire_we   = psr_upd;
      wcmd.ire_nxt  = psr_src[PSR_IRE];
      wcmd.imme_we  = psr_upd;
      wcmd.imme_nxt = psr_src[PSR_IMME];
      wcmd.dmme_we  = psr_upd;
      wcmd.dmme_nxt = psr_src[PSR_DMME];

      // Save registers, exception entry overrides software
      wcmd.epsr_we = epsr_sel | exp_ent;
      if (exp_ent) begin
         wcmd.epsr_nxt = state.psr_q;
      end else begin
         wcmd.epsr_nxt = msr_wdat[PSR_W-1:0] & PSR_USED_MASK;
      end

      wcmd.epc_we  = epc_sel | exp_ent;
      wcmd.epc_nxt = exp_ent ? exp_pc : msr_wdat;

      wcmd.elsa_we  = elsa_sel | exp_ent;
      wcmd.elsa_nxt = exp_ent ? exp_lsa : msr_wdat;
   end

   // Entering and leaving an exception in one cycle has no defined meaning
   a_no_ent_and_ret: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(exp_ent && eret)
   ) else $error("exp_ent and eret asserted together");

endmodule

`default_nettype wire

// ==== verilog/ncpu_msr_file.sv ====
// MSR register file: PSR bits and EPSR, EPC, ELSA with same-cycle bypass and unloaded view
`timescale 1ns/10ps
`default_nettype none

module ncpu_msr_file (
   input  wire                            clk,
   input  wire                            arst_n,
   input  wire                            exp_ent,
   input  wire ncpu_msr_pkg::msr_wcmd_t   wcmd,
   output ncpu_msr_pkg::msr_state_t       state,
   output ncpu_msr_pkg::psr_t             psr,
   output ncpu_msr_pkg::psr_t             psr_nold,
   output ncpu_msr_pkg::psr_t             epsr,
   output ncpu_msr_pkg::word_t            epc,
   output ncpu_msr_pkg::word_t            elsa
);
   import ncpu_msr_pkg::*;

   logic  cc_q;
   logic  rm_q;
   logic  ire_q;
   logic  imme_q;
   logic  dmme_q;
   psr_t  epsr_q;
   word_t epc_q;
   word_t elsa_q;

   // Exception entry load applied on top of the decoder command
   logic rm_we;
   logic rm_nxt;
   logic ire_we;
   logic ire_nxt;
   logic imme_we;
   logic imme_nxt;
   logic dmme_we;
   logic dmme_nxt;

   // Place the five fields at their PSR positions
   function automatic psr_t pack_psr(input logic cc, input logic rm, input logic ire,
                                     input logic imme, input logic dmme);
      psr_t p;
      p           = '0;
      p[PSR_CC]   = cc;
      p[PSR_RM]   = rm;
      p[PSR_IRE]  = ire;
      p[PSR_IMME] = imme;
      p[PSR_DMME] = dmme;
      return p;
   endfunction

   // Exception entry: root mode on, interrupts and MMUs off, cc untouched
   assign rm_we    = wcmd.rm_we | exp_ent;
   assign rm_nxt   = wcmd.rm_nxt | exp_ent;
   assign ire_we   = wcmd.ire_we | exp_ent;
   assign ire_nxt  = wcmd.ire_nxt & ~exp_ent;
   assign imme_we  = wcmd.imme_we | exp_ent;
   assign imme_nxt = wcmd.imme_nxt & ~exp_ent;
   assign dmme_we  = wcmd.dmme_we | exp_ent;
   assign dmme_nxt = wcmd.dmme_nxt & ~exp_ent;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cc_q   <= PSR_RESET[PSR_CC];
         rm_q   <= PSR_RESET[PSR_RM];
         ire_q  <= PSR_RESET[PSR_IRE];
         imme_q <= PSR_RESET[PSR_IMME];
         dmme_q <= PSR_RESET[PSR_DMME];
         epsr_q <= '0;
         epc_q  <= '0;
         elsa_q <= '0;
      end else begin
         if (wcmd.cc_we) cc_q <= wcmd.cc_nxt;
         if (rm_we) rm_q <= rm_nxt;
         if (ire_we) ire_q <= ire_nxt;
         if (imme_we) imme_q <= imme_nxt;
         if (dmme_we) dmme_q <= dmme_nxt;
         if (wcmd.epsr_we) epsr_q <= wcmd.epsr_nxt;
         if (wcmd.epc_we) epc_q <= wcmd.epc_nxt;
         if (wcmd.elsa_we) elsa_q <= wcmd.elsa_nxt;
      end
   end

   // Registered values back to the decoder
   assign state.psr_q  = pack_psr(cc_q, rm_q, ire_q, imme_q, dmme_q);
   assign state.epsr_q = epsr_q;
   assign state.epc_q  = epc_q;
   assign state.elsa_q = elsa_q;

   // Bypassed view including the exception load
   assign psr = pack_psr(wcmd.cc_we ? wcmd.cc_nxt : cc_q,
                         rm_we ? rm_nxt : rm_q,
                         ire_we ? ire_nxt : ire_q,
                         imme_we ? imme_nxt : imme_q,
                         dmme_we ? dmme_nxt : dmme_q);

   // Same view without the exception load
   assign psr_nold = pack_psr(wcmd.cc_we ? wcmd.cc_nxt : cc_q,
                              wcmd.rm_we ? wcmd.rm_nxt : rm_q,
                              wcmd.ire_we ? wcmd.ire_nxt : ire_q,
                              wcmd.imme_we ? wcmd.imme_nxt : imme_q,
                              wcmd.dmme_we ? wcmd.dmme_nxt : dmme_q);

   assign epsr = wcmd.epsr_we ? wcmd.epsr_nxt : epsr_q;
   assign epc  = wcmd.epc_we ? wcmd.epc_nxt : epc_q;
   assign elsa = wcmd.elsa_we ? wcmd.elsa_nxt : elsa_q;

   // Reserved bits of the saved status word stay clear
   a_epsr_reserved_zero: assert property (
      @(posedge clk) disable iff (!arst_n)
      (epsr & ~PSR_USED_MASK) == '0
   ) else $error("reserved EPSR bit set");

endmodule

`default_nettype wire

// ==== verilog/ncpu_msr_pkg.sv ====
// Widths, register addresses, PSR bit positions, reset and ID constants, MSR structs
`default_nettype none

package ncpu_msr_pkg;

   localparam int WORD_W = 32;
   localparam int PSR_W  = 10;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [PSR_W-1:0]  psr_t;

   // Register addresses, codes 6 and 7 are unmapped
   typedef enum logic [2:0] {
      MSR_PSR    = 3'd0,
      MSR_CPUID  = 3'd1,
      MSR_EPSR   = 3'd2,
      MSR_EPC    = 3'd3,
      MSR_ELSA   = 3'd4,
      MSR_COREID = 3'd5
   } msr_addr_t;

   // PSR field positions
   localparam int PSR_CC   = 0;
   localparam int PSR_RM   = 4;
   localparam int PSR_IRE  = 5;
   localparam int PSR_IMME = 6;
   localparam int PSR_DMME = 7;

   // Implemented PSR bits, the rest read zero
   localparam psr_t PSR_USED_MASK = psr_t'((1 << PSR_CC) | (1 << PSR_RM) | (1 << PSR_IRE) |
                                           (1 << PSR_IMME) | (1 << PSR_DMME));

   // Root mode on, everything else off
   localparam psr_t PSR_RESET = psr_t'(1 << PSR_RM);

   // CPUID fields
   localparam logic [7:0] CPUID_VER   = 8'd1;
   localparam logic [9:0] CPUID_REV   = 10'd0;
   localparam logic       CPUID_FIMM  = 1'b1;
   localparam logic       CPUID_FDMM  = 1'b1;
   localparam logic       CPUID_FICA  = 1'b0;
   localparam logic       CPUID_FDCA  = 1'b0;
   localparam logic       CPUID_FDBG  = 1'b0;
   localparam logic       CPUID_FFPU  = 1'b0;
   localparam logic       CPUID_FIRQC = 1'b1;
   localparam logic       CPUID_FTSC  = 1'b1;

   localparam word_t CPUID_WORD = word_t'({CPUID_FTSC, CPUID_FIRQC, CPUID_FFPU, CPUID_FDBG,
                                           CPUID_FDCA, CPUID_FICA, CPUID_FDMM, CPUID_FIMM,
                                           CPUID_REV, CPUID_VER});

   localparam word_t COREID_WORD = '0;

   // Write command from decoder to register file
   typedef struct packed {
      logic  cc_we;
      logic  cc_nxt;
      logic  rm_we;
      logic  rm_nxt;
      logic  ire_we;
      logic  ire_nxt;
      logic  imme_we;
      logic  imme_nxt;
      logic  dmme_we;
      logic  dmme_nxt;
      logic  epsr_we;
      psr_t  epsr_nxt;
      logic  epc_we;
      word_t epc_nxt;
      logic  elsa_we;
      word_t elsa_nxt;
   } msr_wcmd_t;

   // Registered contents, no bypass
   typedef struct packed {
      psr_t  psr_q;
      psr_t  epsr_q;
      word_t epc_q;
      word_t elsa_q;
   } msr_state_t;

endpackage

`default_nettype wire

// ==== verilog/ncpu_msr_read.sv ====
// MSR read port: address-selected register contents onto the read data bus
`timescale 1ns/10ps
`default_nettype none

module ncpu_msr_read (
   input  wire ncpu_msr_pkg::msr_addr_t   msr_raddr,
   // Bypassed views from the register file
   input  wire ncpu_msr_pkg::psr_t        psr,
   input  wire ncpu_msr_pkg::psr_t        epsr,
   input  wire ncpu_msr_pkg::word_t       epc,
   input  wire ncpu_msr_pkg::word_t       elsa,
   output ncpu_msr_pkg::word_t            msr_rdat
);
   import ncpu_msr_pkg::*;

   word_t psr_word;
   word_t epsr_word;

   // Status words widened to the bus
   assign psr_word  = {{(WORD_W-PSR_W){1'b0}}, psr};
   assign epsr_word = {{(WORD_W-PSR_W){1'b0}}, epsr};

   always_comb begin
      case (msr_raddr)
         MSR_PSR: begin
            msr_rdat = psr_word;
         end
         MSR_CPUID: begin
            msr_rdat = CPUID_WORD;
         end
         MSR_EPSR: begin
            msr_rdat = epsr_word;
         end
         MSR_EPC: begin
            msr_rdat = epc;
         end
         MSR_ELSA: begin
            msr_rdat = elsa;
         end
         MSR_COREID: begin
            msr_rdat = COREID_WORD;
         end
         // Unmapped codes
         default: begin
            msr_rdat = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/ncpu_msr_top.sv ====
// MSR block top level: decoder, register file and read port
`timescale 1ns/10ps
`default_nettype none

module ncpu_msr_top (
   input  wire                            clk,
   input  wire                            arst_n,
   // Software write
   input  wire                            msr_we,
   input  wire ncpu_msr_pkg::msr_addr_t   msr_waddr,
   input  wire ncpu_msr_pkg::word_t       msr_wdat,
   // Exception entry and return
   input  wire                            exp_ent,
   input  wire ncpu_msr_pkg::word_t       exp_pc,
   input  wire ncpu_msr_pkg::word_t       exp_lsa,
   input  wire                            eret,
   // Read port
   input  wire ncpu_msr_pkg::msr_addr_t   msr_raddr,
   output wire ncpu_msr_pkg::word_t       msr_rdat,
   // Status word views
   output wire ncpu_msr_pkg::psr_t        psr,
   output wire ncpu_msr_pkg::psr_t        psr_nold
);
   import ncpu_msr_pkg::*;

   wire msr_wcmd_t  wcmd;
   wire msr_state_t state;
   wire psr_t       epsr;
   wire word_t      epc;
   wire word_t      elsa;

   ncpu_msr_cmd_decode u_decode (
      .clk       (clk),
      .arst_n    (arst_n),
      .msr_we    (msr_we),
      .msr_waddr (msr_waddr),
      .msr_wdat  (msr_wdat),
      .exp_ent   (exp_ent),
      .exp_pc    (exp_pc),
      .exp_lsa   (exp_lsa),
      .eret      (eret),
      .state     (state),
      .wcmd      (wcmd)
   );

   ncpu_msr_file u_file (
      .clk      (clk),
      .arst_n   (arst_n),
      .exp_ent  (exp_ent),
      .wcmd     (wcmd),
      .state    (state),
      .psr      (psr),
      .psr_nold (psr_nold),
      .epsr     (epsr),
      .epc      (epc),
      .elsa     (elsa)
   );

   ncpu_msr_read u_read (
      .msr_raddr (msr_raddr),
      .psr       (psr),
      .epsr      (epsr),
      .epc       (epc),
      .elsa      (elsa),
      .msr_rdat  (msr_rdat)
   );

endmodule

`default_nettype wire
